// ==== src/uart_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// shared constants and state types for the 8N1 serial port
// import into any block that needs bit timing or FSM states
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package uart_pkg;

  localparam int CLK_FREQ  = 250_000_000;       // 4 ns clock
  localparam int BAUD_RATE = 15_625_000;
  localparam int BIT_TIME  = CLK_FREQ / BAUD_RATE;  // clocks per serial bit
  localparam int HALF_BIT  = BIT_TIME / 2;      // start-bit check point
  localparam int CNT_W     = $clog2(BIT_TIME);
  localparam int DATA_BITS = 8;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP,
    TX_WAIT_GO_LOW  // stop bit done, waiting for go to drop
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage

`default_nettype wire

// ==== src/uart_rx_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// receive results from the rx engine to the host register block
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

interface uart_rx_if;

  logic [uart_pkg::DATA_BITS-1:0] data;  // last received byte
  logic                           valid;      // one cycle per finished frame
  logic                           frame_err;  // stop bit sampled low, qualified by valid
  logic                           active;     // frame in progress

  modport engine (output data, valid, frame_err, active);
  modport host   (input data, valid, frame_err, active);

endinterface

`default_nettype wire

// ==== src/uart_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// 8N1 transmit engine, one byte per go request
// hold go until busy is seen, engine idles again once go is low
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_data,
  input  logic       go,
  output logic       txd,
  output logic       busy
);
  import uart_pkg::*;

  tx_state_t                        state;
  logic [CNT_W-1:0]                 cnt;       // counts down one bit time
  logic [$clog2(DATA_BITS)-1:0]     bit_idx;   // data bit currently on the line
  logic [DATA_BITS-1:0]             shreg;     // remaining data bits, lsb goes out next

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
      busy    <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (go) begin
            busy  <= 1'b1;
            txd   <= 1'b0;                 // start bit
            shreg <= tx_data;
            cnt   <= CNT_W'(BIT_TIME - 1); // first clock of the start bit is this one
            state <= TX_START;
          end
        end

        TX_START: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            txd     <= shreg[0];
            shreg   <= shreg >> 1;
            bit_idx <= '0;
            cnt     <= CNT_W'(BIT_TIME - 1);
            state   <= TX_DATA;
          end
        end

        TX_DATA: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            cnt <= CNT_W'(BIT_TIME - 1);
            if (bit_idx == DATA_BITS - 1) begin
              txd   <= 1'b1;  // stop bit
              state <= TX_STOP;
            end else begin
              txd     <= shreg[0];
              shreg   <= shreg >> 1;
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end

        TX_STOP: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            busy  <= 1'b0;
            state <= TX_WAIT_GO_LOW;
          end
        end

        TX_WAIT_GO_LOW: begin
          // host must release go before another byte is taken
          if (!go) begin
            state <= TX_IDLE;
          end
        end

        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// 8N1 receive engine, samples each bit at its middle
// results leave through the engine side of uart_rx_if
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rxd,
  uart_rx_if.engine  rx
);
  import uart_pkg::*;

  logic [1:0]                   sync_q;   // two-flop synchronizer
  logic                         rxd_s;
  logic                         rxd_prev;
  rx_state_t                    state;
  logic [CNT_W-1:0]             cnt;
  logic [$clog2(DATA_BITS)-1:0] bit_idx;
  logic [DATA_BITS-1:0]         shreg;    // bits arrive lsb first
  logic                         valid_q;
  logic                         frame_err_q;

  assign rxd_s = sync_q[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q   <= 2'b11;  // idle line level
      rxd_prev <= 1'b1;
    end else begin
      sync_q   <= {sync_q[0], rxd};
      rxd_prev <= rxd_s;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= RX_IDLE;
      cnt         <= '0;
      bit_idx     <= '0;
      valid_q     <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (rxd_prev && !rxd_s) begin  // falling edge, possible start bit
            cnt   <= CNT_W'(HALF_BIT - 1);
            state <= RX_START;
          end
        end

        RX_START: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            if (!rxd_s) begin
              bit_idx <= '0;
              cnt     <= CNT_W'(BIT_TIME - 1);
              state   <= RX_DATA;
            end else begin
              state <= RX_IDLE;  // glitch, line went back high
            end
          end
        end

        RX_DATA: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            shreg   <= {rxd_s, shreg[DATA_BITS-1:1]};
            bit_idx <= bit_idx + 1'b1;
            cnt     <= CNT_W'(BIT_TIME - 1);
            if (bit_idx == DATA_BITS - 1) begin
              state <= RX_STOP;
            end
          end
        end

        RX_STOP: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            valid_q     <= 1'b1;
            frame_err_q <= !rxd_s;  // stop bit must be high
            state       <= RX_IDLE;
          end
        end

        default: state <= RX_IDLE;
      endcase
    end
  end

  assign rx.data      = shreg;  // stable from last data sample until next frame
  assign rx.valid     = valid_q;
  assign rx.frame_err = frame_err_q;
  assign rx.active    = (state != RX_IDLE);

endmodule

`default_nettype wire

// ==== src/port_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// host side registers: tx byte with go/busy exchange, one-byte rx buffer
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module port_regs (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr_en,
  input  logic [7:0] wr_data,
  input  logic       rd_en,
  input  logic       busy,
  output logic [7:0] tx_data,
  output logic       go,
  output logic [7:0] rd_data,
  output logic       tx_busy,
  output logic       rx_ready,
  output logic       rx_overrun,
  output logic       rx_frame_err,
  output logic       rx_active,
  uart_rx_if.host    rx
);

  logic pending;  // byte accepted, engine not yet back to idle
  logic rd_ack;

  assign tx_busy = pending | busy;
  assign rd_ack  = rd_en && rx_ready;

  // transmit side
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      go      <= 1'b0;
      pending <= 1'b0;
    end else begin
      if (wr_en && !tx_busy) begin
        tx_data <= wr_data;
        go      <= 1'b1;
        pending <= 1'b1;
      end else if (go && busy) begin
        go <= 1'b0;  // engine has taken the byte
      end else if (pending && !go && !busy) begin
        pending <= 1'b0;
      end
    end
  end

  // receive buffer and status flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data      <= '0;
      rx_ready     <= 1'b0;
      rx_overrun   <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      if (rx.valid && (!rx_ready || rd_ack)) begin
        rd_data      <= rx.data;
        rx_ready     <= 1'b1;
        rx_frame_err <= rx.frame_err;
        rx_overrun   <= 1'b0;
      end else if (rx.valid) begin
        rx_overrun <= 1'b1;  // new byte dropped, old one kept
      end else if (rd_ack) begin
        rx_ready     <= 1'b0;
        rx_overrun   <= 1'b0;
        rx_frame_err <= 1'b0;
      end
    end
  end

  assign rx_active = rx.active;

endmodule

`default_nettype wire

// ==== src/uart_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// serial port top, host registers plus tx and rx engines
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module uart_port (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr_en,
  input  logic [7:0] wr_data,
  input  logic       rd_en,
  output logic [7:0] rd_data,
  output logic       tx_busy,
  output logic       rx_ready,
  output logic       rx_overrun,
  output logic       rx_frame_err,
  output logic       rx_active,
  input  logic       rxd,
  output logic       txd
);
  import uart_pkg::*;

  logic [DATA_BITS-1:0] tx_data;
  logic                 go;
  logic                 busy;

  uart_rx_if rx_bus ();

  port_regs u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .rd_en        (rd_en),
    .busy         (busy),
    .tx_data      (tx_data),
    .go           (go),
    .rd_data      (rd_data),
    .tx_busy      (tx_busy),
    .rx_ready     (rx_ready),
    .rx_overrun   (rx_overrun),
    .rx_frame_err (rx_frame_err),
    .rx_active    (rx_active),
    .rx           (rx_bus.host)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_data (tx_data),
    .go      (go),
    .txd     (txd),
    .busy    (busy)
  );

  uart_rx u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rxd   (rxd),
    .rx    (rx_bus.engine)
  );

endmodule

`default_nettype wire

// ==== bench/uart_port_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// concurrent checks on tx idle level, go/busy exchange and rx flags
// bound into uart_port at the end of this file
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module uart_port_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                txd,
  input uart_pkg::tx_state_t tx_state,
  input logic                go,
  input logic                busy,
  input logic                rx_valid,
  input logic                rx_ready,
  input logic                rx_overrun
);
  import uart_pkg::*;

  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    (tx_state == TX_IDLE) |-> txd)
    else $error("txd low while the tx engine is idle");

  ready_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rx_ready) |-> $past(rx_valid))
    else $error("rx_ready rose without a valid pulse");

  go_held_until_busy: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(go) |-> $past(busy))
    else $error("go dropped before busy was seen");

  overrun_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    rx_overrun |-> rx_ready)
    else $error("rx_overrun set while rx_ready is low");

endmodule

bind uart_port uart_port_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .txd        (txd),
  .tx_state   (u_tx.state),
  .go         (go),
  .busy       (busy),
  .rx_valid   (rx_bus.valid),
  .rx_ready   (rx_ready),
  .rx_overrun (rx_overrun)
);

`default_nettype wire

// ==== bench/uart_port_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// directed testbench for the serial port with a line model, loopback and bad frames
// compile with flist.f, uart_port_tb is the top
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module uart_port_tb;
  import uart_pkg::*;

  localparam int TIMEOUT_CYCLES = 40 * 10 * BIT_TIME + 200;

  logic       clk;
  logic       rst_n;
  logic       wr_en;
  logic [7:0] wr_data;
  logic       rd_en;
  logic [7:0] rd_data;
  logic       tx_busy;
  logic       rx_ready;
  logic       rx_overrun;
  logic       rx_frame_err;
  logic       rx_active;
  logic       txd;
  wire        rxd;
  logic       loopback;  // rxd follows txd when set
  logic       tb_line;   // line level driven by the sender task
  int         seed;
  int         errors;
  int         n_pass;
  int         n_fail;
  int         cycles = 0;

  assign rxd = loopback ? txd : tb_line;

  uart_port dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int start_errors);
    if (errors == start_errors) begin
      n_pass++;
      $display("%s: ok", name);
    end else begin
      n_fail++;
      $display("%s: %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic write_byte(input logic [7:0] b);
    wr_data = b;
    wr_en   = 1'b1;
    @(negedge clk);
    wr_en   = 1'b0;
  endtask

  task automatic read_byte;
    rd_en = 1'b1;
    @(negedge clk);
    rd_en = 1'b0;
    if (rx_ready !== 1'b0) report_mismatch("rx_ready", 0, rx_ready);
  endtask

  task automatic wait_tx_idle(input int limit);
    int n;
    n = 0;
    while (tx_busy && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (tx_busy) report_problem("tx_busy did not drop in time");
  endtask

  task automatic wait_rx_ready(input int limit);
    int n;
    n = 0;
    while (!rx_ready && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!rx_ready) report_problem("rx_ready never went high");
  endtask

  // 8N1 frame on the tb side of the line mux
  task automatic send_frame(input logic [7:0] b, input logic stop);
    tb_line = 1'b0;
    repeat (BIT_TIME) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      tb_line = b[i];  // lsb first
      repeat (BIT_TIME) @(negedge clk);
    end
    tb_line = stop;
    repeat (BIT_TIME) @(negedge clk);
    tb_line = 1'b1;
    repeat (2) @(negedge clk);
  endtask

  task automatic capture_frame(output logic [7:0] b, output logic stop, output logic found);
    int n;
    n = 0;
    b = '0;
    stop = 1'b0;
    while (txd && n < 4 * BIT_TIME) begin
      @(negedge clk);
      n++;
    end
    found = !txd;
    if (found) begin
      repeat (HALF_BIT) @(negedge clk);  // middle of the start bit
      if (txd !== 1'b0) report_mismatch("txd start bit", 0, txd);
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_TIME) @(negedge clk);
        b[i] = txd;
      end
      repeat (BIT_TIME) @(negedge clk);
      stop = txd;
    end
  endtask

  task automatic test_reset;
    int e0;
    e0 = errors;
    if (txd !== 1'b1) report_mismatch("txd", 1, txd);
    if (tx_busy !== 1'b0) report_mismatch("tx_busy", 0, tx_busy);
    if (rx_ready !== 1'b0) report_mismatch("rx_ready", 0, rx_ready);
    if (rx_overrun !== 1'b0) report_mismatch("rx_overrun", 0, rx_overrun);
    if (rx_frame_err !== 1'b0) report_mismatch("rx_frame_err", 0, rx_frame_err);
    if (rx_active !== 1'b0) report_mismatch("rx_active", 0, rx_active);
    if (rd_data !== 8'h00) report_mismatch("rd_data", 0, rd_data);
    finish_test("reset state", e0);
  endtask

  task automatic test_tx_frame;
    int         e0;
    int         start;
    logic [7:0] b;
    logic [7:0] got;
    logic       stop;
    logic       found;
    e0 = errors;
    b = 8'($random(seed));
    start = cycles;
    write_byte(b);
    if (tx_busy !== 1'b1) report_mismatch("tx_busy", 1, tx_busy);
    capture_frame(got, stop, found);
    if (!found) report_problem("no start bit seen on txd");
    if (got !== b) report_mismatch("txd data", b, got);
    if (stop !== 1'b1) report_mismatch("txd stop bit", 1, stop);
    wait_tx_idle(10 * BIT_TIME + 8 - (cycles - start));
    finish_test("single transmit", e0);
  endtask

  task automatic test_write_ignored;
    int         e0;
    int         low_cycles;
    logic [7:0] a;
    logic [7:0] got;
    logic       stop;
    logic       found;
    e0 = errors;
    a = 8'($random(seed));
    write_byte(a);
    write_byte(~a);  // lands while tx_busy is high
    capture_frame(got, stop, found);
    if (!found) report_problem("no start bit seen on txd");
    if (got !== a) report_mismatch("txd data", a, got);
    wait_tx_idle(4 * BIT_TIME);
    low_cycles = 0;
    repeat (3 * BIT_TIME) begin
      @(negedge clk);
      if (!txd) low_cycles++;
    end
    if (low_cycles != 0) report_problem("a second frame appeared on txd");
    finish_test("write while busy", e0);
  endtask

  task automatic test_loopback;
    int         e0;
    logic [7:0] b;
    e0 = errors;
    loopback = 1'b1;
    for (int i = 0; i < 8; i++) begin
      b = 8'($random(seed));
      wait_tx_idle(12 * BIT_TIME);
      write_byte(b);
      repeat (2 * BIT_TIME) @(negedge clk);  // inside the first data bit
      if (rx_active !== 1'b1) report_mismatch("rx_active", 1, rx_active);
      wait_rx_ready(12 * BIT_TIME);
      if (rx_active !== 1'b0) report_mismatch("rx_active", 0, rx_active);
      if (rd_data !== b) report_mismatch("rd_data", b, rd_data);
      if (rx_frame_err !== 1'b0) report_mismatch("rx_frame_err", 0, rx_frame_err);
      read_byte;
    end
    wait_tx_idle(4 * BIT_TIME);
    loopback = 1'b0;
    finish_test("loopback", e0);
  endtask

  task automatic test_frame_error;
    int         e0;
    logic [7:0] b;
    e0 = errors;
    b = 8'($random(seed));
    send_frame(b, 1'b0);  // stop bit held low
    wait_rx_ready(4 * BIT_TIME);
    if (rx_frame_err !== 1'b1) report_mismatch("rx_frame_err", 1, rx_frame_err);
    if (rd_data !== b) report_mismatch("rd_data", b, rd_data);
    read_byte;
    if (rx_frame_err !== 1'b0) report_mismatch("rx_frame_err", 0, rx_frame_err);
    finish_test("framing error", e0);
  endtask

  task automatic test_overrun;
    int         e0;
    logic [7:0] a;
    logic [7:0] c;
    e0 = errors;
    a = 8'($random(seed));
    c = 8'($random(seed));
    send_frame(a, 1'b1);
    send_frame(c, 1'b1);
    wait_rx_ready(4 * BIT_TIME);
    if (rx_overrun !== 1'b1) report_mismatch("rx_overrun", 1, rx_overrun);
    if (rd_data !== a) report_mismatch("rd_data", a, rd_data);
    read_byte;
    if (rx_overrun !== 1'b0) report_mismatch("rx_overrun", 0, rx_overrun);
    finish_test("receive overrun", e0);
  endtask

  initial begin
    seed     = 11;
    errors   = 0;
    n_pass   = 0;
    n_fail   = 0;
    rst_n    = 1'b0;
    wr_en    = 1'b0;
    wr_data  = 8'h00;
    rd_en    = 1'b0;
    loopback = 1'b0;
    tb_line  = 1'b1;  // idle line
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset;
    test_tx_frame;
    test_write_ignored;
    test_loopback;
    test_frame_error;
    test_overrun;
    $display("passing tests: %0d, failing tests: %0d", n_pass, n_fail);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
src/uart_pkg.sv
src/uart_rx_if.sv
src/uart_tx.sv
src/uart_rx.sv
src/port_regs.sv
src/uart_port.sv
bench/uart_port_sva.sv
bench/uart_port_tb.sv

// ==== Makefile ====
# Verilator build and run for the uart_port testbench

VERILATOR ?= verilator
TOP       ?= uart_port_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= test passed

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
